/* design/usb_bridge_pkg.sv */
//----------------------------------------------------------------------
// Shared definitions for the USB command bridge
// Word, AXI and stream widths, fixed AXI ID and burst code
// Command ID and engine state enums, stream and AXI channel structs
//----------------------------------------------------------------------
`default_nettype none

package usb_bridge_pkg;

    // Widths
    localparam int WORD_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int LEN_W    = 8;
    localparam int SEQ_W    = 16;
    localparam int RESP_W   = 2;
    localparam int STRB_W   = 4;
    localparam int AXI_ID_W = 4;

    // Fixed AXI attributes driven by the bridge
    localparam logic [AXI_ID_W-1:0] BRIDGE_AXI_ID = '0;
    localparam logic [1:0]          BURST_INCR    = 2'b01;

    typedef logic [WORD_W-1:0] word_t;

    // Command IDs from header bits 7:0
    // NP writes return a status word, 3xh writes are posted
    typedef enum logic [7:0] {
        CMD_ECHO       = 8'h01,
        CMD_DRAIN      = 8'h02,
        CMD_READ       = 8'h10,
        CMD_WRITE8_NP  = 8'h20,
        CMD_WRITE16_NP = 8'h21,
        CMD_WRITE_NP   = 8'h22,
        CMD_WRITE8     = 8'h30,
        CMD_WRITE16    = 8'h31,
        CMD_WRITE      = 8'h32,
        CMD_GPIO_WR    = 8'h40,
        CMD_GPIO_RD    = 8'h41
    } cmd_id_e;

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_CMD_REQ    = 4'd1,
        ST_CMD_ADDR   = 4'd2,
        ST_ECHO       = 4'd3,
        ST_STATUS     = 4'd4,
        ST_READ_CMD   = 4'd5,
        ST_READ_DATA  = 4'd6,
        ST_WRITE_CMD  = 4'd7,
        ST_WRITE_DATA = 4'd8,
        ST_WRITE_RESP = 4'd9,
        ST_DRAIN      = 4'd10,
        ST_GPIO_WR    = 4'd11,
        ST_GPIO_RD    = 4'd12
    } engine_state_e;

    //------------------------------------------------------------------
    // Channel structs
    //------------------------------------------------------------------
    // Receive and transmit word streams
    typedef struct packed {
        logic  valid;
        word_t data;
    } stream_t;

    // AW and AR
    typedef struct packed {
        logic                valid;
        logic [ADDR_W-1:0]   addr;
        logic [AXI_ID_W-1:0] id;
        logic [LEN_W-1:0]    len;
        logic [1:0]          burst;
    } axi_addr_t;

    typedef struct packed {
        logic              valid;
        word_t             data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic                valid;
        logic [RESP_W-1:0]   resp;
        logic [AXI_ID_W-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic                valid;
        word_t               data;
        logic [RESP_W-1:0]   resp;
        logic [AXI_ID_W-1:0] id;
        logic                last;
    } axi_r_t;

endpackage

`default_nettype wire

/* design/gpio_regs.sv */
//----------------------------------------------------------------------
// GPIO register block beside the command engine
// Output register loaded by the engine, free-running input sampler
//----------------------------------------------------------------------
`default_nettype none

module gpio_regs
(
    input  wire                    clk_i,
    input  wire                    rst_i,
    input  wire                    wr_i,
    input  usb_bridge_pkg::word_t  wdata_i,
    input  usb_bridge_pkg::word_t  gpio_i,
    output usb_bridge_pkg::word_t  gpio_o,
    output usb_bridge_pkg::word_t  rdata_o
);
    import usb_bridge_pkg::*;

    word_t gpio_out_q;
    word_t gpio_in_q;

    // Output pins, written by a GPIO write command
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            gpio_out_q <= '0;
        else if (wr_i)
            gpio_out_q <= wdata_i;
    end

    // Input pins sampled every cycle
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            gpio_in_q <= '0;
        else
            gpio_in_q <= gpio_i;
    end

    assign gpio_o  = gpio_out_q;
    assign rdata_o = gpio_in_q;

    // The engine forwards a received word, so it must be fully defined
    a_wdata_known : assert property (
        @(posedge clk_i) disable iff (rst_i)
        wr_i |-> !$isunknown(wdata_i)
    ) else $error("gpio_regs: unknown bits in wdata_i on write");

endmodule

`default_nettype wire

/* design/cmd_engine.sv */
//----------------------------------------------------------------------
// Command engine of the USB bridge
// Packet FSM with header and address capture, beat counter,
// write strobe generation, AXI master drive and transmit word mux
//----------------------------------------------------------------------
`default_nettype none

module cmd_engine
(
    input  wire                        clk_i,
    input  wire                        rst_i,

    // Word streams
    input  usb_bridge_pkg::stream_t    rx_i,
    output logic                       rx_accept_o,
    output usb_bridge_pkg::stream_t    tx_o,
    input  wire                        tx_accept_i,

    // AXI master
    output usb_bridge_pkg::axi_addr_t  axi_aw_o,
    input  wire                        axi_awready_i,
    output usb_bridge_pkg::axi_w_t     axi_w_o,
    input  wire                        axi_wready_i,
    input  usb_bridge_pkg::axi_b_t     axi_b_i,
    output logic                       axi_bready_o,
    output usb_bridge_pkg::axi_addr_t  axi_ar_o,
    input  wire                        axi_arready_i,
    input  usb_bridge_pkg::axi_r_t     axi_r_i,
    output logic                       axi_rready_o,

    // GPIO register block
    output logic                       gpio_wr_o,
    output usb_bridge_pkg::word_t      gpio_wdata_o,
    input  usb_bridge_pkg::word_t      gpio_rdata_i
);
    import usb_bridge_pkg::*;

    engine_state_e      state_q;
    engine_state_e      next_state;

    cmd_id_e            cmd_id_q;
    logic [LEN_W-1:0]   cmd_len_q;
    logic [SEQ_W-1:0]   cmd_seq_q;
    logic [ADDR_W-1:0]  cmd_addr_q;
    logic [STRB_W-1:0]  wstrb_q;
    logic [LEN_W-1:0]   beat_cnt_q;
    logic [RESP_W-1:0]  resp_q;

    logic               last_beat;
    logic               tx_fire;
    logic               w_fire;
    logic               b_fire;
    logic               r_fire;

    //------------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------------
    // Byte lanes for a write, from size and low address bits
    function automatic logic [STRB_W-1:0] lane_strb(input cmd_id_e cmd,
                                                    input logic [1:0] addr_lo);
        logic [STRB_W-1:0] strb;
        case (cmd)
            CMD_WRITE8, CMD_WRITE8_NP:
                strb = STRB_W'(1) << addr_lo;
            CMD_WRITE16, CMD_WRITE16_NP:
                strb = addr_lo[1] ? 4'b1100 : 4'b0011;
            default:
                strb = '1;
        endcase
        return strb;
    endfunction

    function automatic logic is_posted(input cmd_id_e cmd);
        return (cmd == CMD_WRITE8) || (cmd == CMD_WRITE16) || (cmd == CMD_WRITE);
    endfunction

    assign last_beat = (beat_cnt_q + LEN_W'(1)) == cmd_len_q;

    assign tx_fire = tx_o.valid && tx_accept_i;
    assign w_fire  = axi_w_o.valid && axi_wready_i;
    assign b_fire  = axi_b_i.valid && axi_bready_o;
    assign r_fire  = axi_r_i.valid && axi_rready_o;

    //------------------------------------------------------------------
    // State machine
    //------------------------------------------------------------------
    always_comb
    begin
        next_state = state_q;
        case (state_q)
            ST_IDLE:
                if (rx_i.valid)
                    next_state = ST_CMD_REQ;
            ST_CMD_REQ:
                if (rx_i.valid)
                    next_state = ST_CMD_ADDR;
            ST_CMD_ADDR:
            begin
                // Dispatch on the captured command
                case (cmd_id_q)
                    CMD_ECHO:
                        next_state = (cmd_len_q == '0) ? ST_STATUS : ST_ECHO;
                    CMD_DRAIN:
                        next_state = ST_DRAIN;
                    CMD_READ:
                        next_state = ST_READ_CMD;
                    CMD_WRITE8_NP, CMD_WRITE16_NP, CMD_WRITE_NP,
                    CMD_WRITE8, CMD_WRITE16, CMD_WRITE:
                        next_state = ST_WRITE_CMD;
                    CMD_GPIO_WR:
                        next_state = ST_GPIO_WR;
                    CMD_GPIO_RD:
                        next_state = ST_GPIO_RD;
                    default:
                        next_state = ST_IDLE;
                endcase
            end
            ST_ECHO:
                if (tx_fire && last_beat)
                    next_state = ST_STATUS;
            ST_READ_CMD:
                if (axi_arready_i)
                    next_state = ST_READ_DATA;
            ST_READ_DATA:
                if (r_fire && axi_r_i.last)
                    next_state = ST_STATUS;
            ST_WRITE_CMD:
                if (axi_awready_i)
                    next_state = ST_WRITE_DATA;
            ST_WRITE_DATA:
                if (w_fire && axi_w_o.last)
                    next_state = ST_WRITE_RESP;
            ST_WRITE_RESP:
                if (b_fire)
                    next_state = is_posted(cmd_id_q) ? ST_IDLE : ST_STATUS;
            ST_STATUS:
                if (tx_fire)
                    next_state = ST_IDLE;
            ST_DRAIN:
                // Discard until the host stops sending
                if (!rx_i.valid)
                    next_state = ST_IDLE;
            ST_GPIO_WR:
                if (rx_i.valid)
                    next_state = ST_STATUS;
            ST_GPIO_RD:
                if (tx_fire)
                    next_state = ST_STATUS;
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            state_q <= ST_IDLE;
        else
            state_q <= next_state;
    end

    //------------------------------------------------------------------
    // Header and address capture
    //------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            cmd_id_q  <= CMD_ECHO;
            cmd_len_q <= '0;
        end
        else if (state_q == ST_IDLE && rx_i.valid)
        begin
            cmd_id_q  <= cmd_id_e'(rx_i.data[7:0]);
            cmd_len_q <= rx_i.data[15:8];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_IDLE && rx_i.valid)
            cmd_seq_q <= rx_i.data[31:16];
        // Strobe is fixed for the whole burst
        if (state_q == ST_CMD_REQ && rx_i.valid)
        begin
            cmd_addr_q <= rx_i.data;
            wstrb_q    <= lane_strb(cmd_id_q, rx_i.data[1:0]);
        end
    end

    // Beats moved so far, for echo and write data
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            beat_cnt_q <= '0;
        else if (state_q == ST_IDLE)
            beat_cnt_q <= '0;
        else if ((state_q == ST_ECHO && tx_fire) || w_fire)
            beat_cnt_q <= beat_cnt_q + LEN_W'(1);
    end

    // Response for the status word
    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_IDLE)
            resp_q <= '0;
        else if (b_fire)
            resp_q <= axi_b_i.resp;
        else if (r_fire && axi_r_i.last)
            resp_q <= axi_r_i.resp;
    end

    //------------------------------------------------------------------
    // Stream handshake and transmit mux
    //------------------------------------------------------------------
    always_comb
    begin
        case (state_q)
            ST_IDLE, ST_CMD_REQ, ST_GPIO_WR, ST_DRAIN:
                rx_accept_o = 1'b1;
            ST_ECHO:
                rx_accept_o = tx_accept_i;
            ST_WRITE_DATA:
                rx_accept_o = axi_wready_i;
            default:
                rx_accept_o = 1'b0;
        endcase
    end

    always_comb
    begin
        tx_o.valid = 1'b0;
        tx_o.data  = '0;
        case (state_q)
            ST_ECHO:
                tx_o = rx_i;
            ST_READ_DATA:
            begin
                tx_o.valid = axi_r_i.valid;
                tx_o.data  = axi_r_i.data;
            end
            ST_GPIO_RD:
            begin
                tx_o.valid = 1'b1;
                tx_o.data  = gpio_rdata_i;
            end
            ST_STATUS:
            begin
                // Status word: sequence, response, zero fill
                tx_o.valid = 1'b1;
                tx_o.data  = {{(WORD_W - RESP_W - SEQ_W){1'b0}}, resp_q, cmd_seq_q};
            end
            default:
            begin
                tx_o.valid = 1'b0;
                tx_o.data  = '0;
            end
        endcase
    end

    //------------------------------------------------------------------
    // AXI channels
    //------------------------------------------------------------------
    always_comb
    begin
        axi_aw_o.valid = (state_q == ST_WRITE_CMD);
        axi_aw_o.addr  = cmd_addr_q;
        axi_aw_o.id    = BRIDGE_AXI_ID;
        axi_aw_o.len   = cmd_len_q - LEN_W'(1);
        axi_aw_o.burst = BURST_INCR;

        axi_ar_o.valid = (state_q == ST_READ_CMD);
        axi_ar_o.addr  = cmd_addr_q;
        axi_ar_o.id    = BRIDGE_AXI_ID;
        axi_ar_o.len   = cmd_len_q - LEN_W'(1);
        axi_ar_o.burst = BURST_INCR;
    end

    // Write data passes straight from the receive stream
    always_comb
    begin
        axi_w_o.valid = (state_q == ST_WRITE_DATA) && rx_i.valid;
        axi_w_o.data  = rx_i.data;
        axi_w_o.strb  = wstrb_q;
        axi_w_o.last  = axi_w_o.valid && last_beat;
    end

    assign axi_bready_o = 1'b1;
    assign axi_rready_o = (state_q == ST_READ_DATA) && tx_accept_i;

    // GPIO write on the data word
    assign gpio_wr_o    = (state_q == ST_GPIO_WR) && rx_i.valid;
    assign gpio_wdata_o = rx_i.data;

    //------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------
    a_one_addr_channel : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(axi_aw_o.valid && axi_ar_o.valid)
    ) else $error("cmd_engine: awvalid and arvalid high together");

    a_wlast_with_wvalid : assert property (
        @(posedge clk_i) disable iff (rst_i)
        axi_w_o.last |-> axi_w_o.valid
    ) else $error("cmd_engine: wlast without wvalid");

endmodule

`default_nettype wire

/* design/usb_bridge_top.sv */
//----------------------------------------------------------------------
// Top level of the USB command bridge
// Joins the command engine and the GPIO register block
//----------------------------------------------------------------------
`default_nettype none

module usb_bridge_top
(
    input  wire                        clk_i,
    input  wire                        rst_i,

    // Receive and transmit word streams
    input  usb_bridge_pkg::stream_t    rx_i,
    output logic                       rx_accept_o,
    output usb_bridge_pkg::stream_t    tx_o,
    input  wire                        tx_accept_i,

    // AXI master
    output usb_bridge_pkg::axi_addr_t  axi_aw_o,
    input  wire                        axi_awready_i,
    output usb_bridge_pkg::axi_w_t     axi_w_o,
    input  wire                        axi_wready_i,
    input  usb_bridge_pkg::axi_b_t     axi_b_i,
    output logic                       axi_bready_o,
    output usb_bridge_pkg::axi_addr_t  axi_ar_o,
    input  wire                        axi_arready_i,
    input  usb_bridge_pkg::axi_r_t     axi_r_i,
    output logic                       axi_rready_o,

    // GPIO pins
    input  usb_bridge_pkg::word_t      gpio_i,
    output usb_bridge_pkg::word_t      gpio_o
);
    import usb_bridge_pkg::*;

    logic  gpio_wr;
    word_t gpio_wdata;
    word_t gpio_rdata;

    //------------------------------------------------------------------
    // Command engine
    //------------------------------------------------------------------
    cmd_engine u_engine
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .rx_i           (rx_i),
        .rx_accept_o    (rx_accept_o),
        .tx_o           (tx_o),
        .tx_accept_i    (tx_accept_i),
        .axi_aw_o       (axi_aw_o),
        .axi_awready_i  (axi_awready_i),
        .axi_w_o        (axi_w_o),
        .axi_wready_i   (axi_wready_i),
        .axi_b_i        (axi_b_i),
        .axi_bready_o   (axi_bready_o),
        .axi_ar_o       (axi_ar_o),
        .axi_arready_i  (axi_arready_i),
        .axi_r_i        (axi_r_i),
        .axi_rready_o   (axi_rready_o),
        .gpio_wr_o      (gpio_wr),
        .gpio_wdata_o   (gpio_wdata),
        .gpio_rdata_i   (gpio_rdata)
    );

    //------------------------------------------------------------------
    // GPIO registers
    //------------------------------------------------------------------
    gpio_regs u_gpio
    (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wr_i     (gpio_wr),
        .wdata_i  (gpio_wdata),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o),
        .rdata_o  (gpio_rdata)
    );

endmodule

`default_nettype wire

/* tb/axi_mem_model.sv */
//----------------------------------------------------------------------
// AXI slave memory for the bridge testbench
// 256 words, byte strobes, random ready and valid delays
//----------------------------------------------------------------------
`default_nettype none

module axi_mem_model
(
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire [3:0]                  rnd_i,
    input  usb_bridge_pkg::axi_addr_t  aw_i,
    output logic                       awready_o,
    input  usb_bridge_pkg::axi_w_t     w_i,
    output logic                       wready_o,
    output usb_bridge_pkg::axi_b_t     b_o,
    input  wire                        bready_i,
    input  usb_bridge_pkg::axi_addr_t  ar_i,
    output logic                       arready_o,
    output usb_bridge_pkg::axi_r_t     r_o,
    input  wire                        rready_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import usb_bridge_pkg::*;

    word_t      mem [0:255];
    logic [7:0] wptr;
    logic [7:0] rptr;
    logic [8:0] rleft;
    logic       b_pend;

    // Fill pattern built from the whole word address
    initial
    begin
        for (int a = 0; a < 256; a++)
            mem[a] = {8'(a) ^ 8'h5A, 8'(a), ~8'(a), 8'(a) + 8'h11};
    end

    always @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            awready_o <= 1'b0;
            arready_o <= 1'b0;
            wready_o  <= 1'b0;
            b_o       <= '0;
            r_o       <= '0;
            rleft     <= '0;
            b_pend    <= 1'b0;
        end
        else
        begin
            awready_o <= rnd_i[0];
            arready_o <= rnd_i[1];
            wready_o  <= rnd_i[2];
            if (aw_i.valid && awready_o)
                wptr <= aw_i.addr[9:2];
            if (ar_i.valid && arready_o)
            begin
                rptr  <= ar_i.addr[9:2];
                rleft <= 9'(ar_i.len) + 9'd1;
            end
            // Write beats, one lane at a time
            if (w_i.valid && wready_o)
            begin
                for (int i = 0; i < 4; i++)
                    if (w_i.strb[i])
                        mem[wptr][8*i +: 8] <= w_i.data[8*i +: 8];
                wptr <= wptr + 8'd1;
                if (w_i.last)
                    b_pend <= 1'b1;
            end
            if (b_o.valid && bready_i)
                b_o.valid <= 1'b0;
            if (b_pend && !b_o.valid && rnd_i[3])
            begin
                b_o    <= '{valid: 1'b1, resp: 2'b00, id: '0};
                b_pend <= 1'b0;
            end
            // Read beats with random gaps
            if (r_o.valid && rready_i)
                r_o.valid <= 1'b0;
            if ((!r_o.valid || rready_i) && rleft != 0 && rnd_i[3])
            begin
                r_o   <= '{valid: 1'b1, data: mem[rptr], resp: 2'b00, id: '0,
                           last: (rleft == 9'd1)};
                rptr  <= rptr + 8'd1;
                rleft <= rleft - 9'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/usb_bridge_tb.sv */
//----------------------------------------------------------------------
// Testbench for the USB command bridge
// Clock, reset, LFSR, packet sequences, assertions, watchdog
//----------------------------------------------------------------------
`default_nettype none

module usb_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import usb_bridge_pkg::*;

    localparam int NUM_PKTS = 15;

    logic      clk_i = 1'b0;
    logic      rst_i;
    stream_t   rx_q;
    logic      rx_accept;
    stream_t   tx;
    logic      tx_accept_q = 1'b0;
    axi_addr_t aw;
    axi_addr_t ar;
    axi_w_t    w;
    axi_b_t    b;
    axi_r_t    r;
    logic      awready, wready, bready, arready, rready;
    word_t     gpio_in;
    word_t     gpio_out;
    logic [3:0] rnd_q = '0;
    logic [31:0] lfsr_s = 32'd67069;

    // Expected transmit words and memory shadow
    word_t exp_mem [0:511];
    int    wr_ptr = 0;
    int    rd_ptr = 0;
    word_t shadow [0:255];
    word_t exp_gpio = '0;
    logic [7:0] exp_len = '0;

    always #20 clk_i = ~clk_i;

    usb_bridge_top dut_i
    (
        .clk_i(clk_i), .rst_i(rst_i), .rx_i(rx_q), .rx_accept_o(rx_accept),
        .tx_o(tx), .tx_accept_i(tx_accept_q),
        .axi_aw_o(aw), .axi_awready_i(awready), .axi_w_o(w), .axi_wready_i(wready),
        .axi_b_i(b), .axi_bready_o(bready), .axi_ar_o(ar), .axi_arready_i(arready),
        .axi_r_i(r), .axi_rready_o(rready), .gpio_i(gpio_in), .gpio_o(gpio_out)
    );

    axi_mem_model u_mem
    (
        .clk_i(clk_i), .rst_i(rst_i), .rnd_i(rnd_q),
        .aw_i(aw), .awready_o(awready), .w_i(w), .wready_o(wready),
        .b_o(b), .bready_i(bready), .ar_i(ar), .arready_o(arready),
        .r_o(r), .rready_i(rready)
    );

    //------------------------------------------------------------------
    // Random bits and helpers
    //------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(posedge clk_i)
    begin
        logic [5:0] bits;
        for (int k = 0; k < 6; k++)
        begin
            lfsr_s  = lfsr_step(lfsr_s);
            bits[k] = lfsr_s[0];
        end
        rnd_q       <= bits[3:0];
        tx_accept_q <= bits[4] | bits[5];
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic word_t pattern_word(input logic [15:0] seq, input int i);
        return {seq ^ 16'hA5C3, 8'(i) * 8'h1D, 8'(i)};
    endfunction

    // Byte lanes by write size and address, decided lane by lane
    function automatic logic [3:0] lane_mask(input cmd_id_e cmd, input logic [1:0] lo);
        logic [3:0] m;
        for (int k = 0; k < 4; k++)
        begin
            if (cmd == CMD_WRITE8 || cmd == CMD_WRITE8_NP)
                m[k] = (k == lo);
            else if (cmd == CMD_WRITE16 || cmd == CMD_WRITE16_NP)
                m[k] = ((k / 2) == lo[1]);
            else
                m[k] = 1'b1;
        end
        return m;
    endfunction

    task automatic push_exp(input word_t v);
        exp_mem[wr_ptr] = v;
        wr_ptr++;
    endtask

    task automatic send_word(input word_t v);
        rx_q.valid <= 1'b1;
        rx_q.data  <= v;
        do @(posedge clk_i); while (!rx_accept);
    endtask

    task automatic rx_idle();
        rx_q.valid <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic wait_drained();
        while (rd_ptr != wr_ptr)
            @(posedge clk_i);
    endtask

    task automatic send_head(input cmd_id_e cmd, input int n, input logic [15:0] seq,
                             input word_t addr);
        send_word({seq, 8'(n), cmd});
        send_word(addr);
    endtask

    task automatic run_echo(input logic [15:0] seq, input int n);
        for (int i = 0; i < n; i++)
            push_exp(pattern_word(seq, i));
        push_exp({16'h0, seq});
        send_head(CMD_ECHO, n, seq, '0);
        for (int i = 0; i < n; i++)
            send_word(pattern_word(seq, i));
        rx_idle();
        wait_drained();
    endtask

    task automatic run_write(input cmd_id_e cmd, input logic [15:0] seq, input word_t addr,
                             input int n);
        logic [3:0] m;
        logic       posted;
        word_t      d;
        m       = lane_mask(cmd, addr[1:0]);
        posted  = (cmd == CMD_WRITE8 || cmd == CMD_WRITE16 || cmd == CMD_WRITE);
        exp_len = 8'(n - 1);
        for (int i = 0; i < n; i++)
        begin
            d = pattern_word(seq, i);
            for (int k = 0; k < 4; k++)
                if (m[k])
                    shadow[addr[9:2] + i][8*k +: 8] = d[8*k +: 8];
        end
        if (!posted)
            push_exp({16'h0, seq});
        send_head(cmd, n, seq, addr);
        for (int i = 0; i < n; i++)
            send_word(pattern_word(seq, i));
        rx_idle();
        if (posted)
            do @(posedge clk_i); while (!(b.valid && bready));
        else
            wait_drained();
    endtask

    task automatic run_read(input logic [15:0] seq, input word_t addr, input int n);
        exp_len = 8'(n - 1);
        for (int i = 0; i < n; i++)
            push_exp(shadow[addr[9:2] + i]);
        push_exp({16'h0, seq});
        send_head(CMD_READ, n, seq, addr);
        rx_idle();
        wait_drained();
    endtask

    //------------------------------------------------------------------
    // Checking
    //------------------------------------------------------------------
    always @(posedge clk_i)
        if (!rst_i && tx.valid && tx_accept_q)
            rd_ptr <= rd_ptr + 1;

    a_tx_expected : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (tx.valid && tx_accept_q) |-> (rd_ptr != wr_ptr)
    ) else report_fail("Transmit word sent when none was expected");

    a_tx_value : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (tx.valid && tx_accept_q && rd_ptr != wr_ptr) |-> (tx.data == exp_mem[rd_ptr])
    ) else report_fail($sformatf("Fail tx_o.data expected %h actual %h",
                                 $sampled(exp_mem[rd_ptr]), $sampled(tx.data)));

    a_gpio_value : assert property (
        @(posedge clk_i) disable iff (rst_i)
        gpio_out == exp_gpio
    ) else report_fail($sformatf("Fail gpio_o expected %h actual %h",
                                 $sampled(exp_gpio), $sampled(gpio_out)));

    a_aw_hold : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (aw.valid && !awready) |=> aw.valid
    ) else report_fail("AW valid dropped before it was accepted");

    // Length, burst type and ID on each address handshake
    a_aw_attr : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (aw.valid && awready) |-> ({aw.len, aw.burst, aw.id} == {exp_len, 2'b01, 4'h0})
    ) else report_fail($sformatf("Fail axi_aw_o len/burst/id expected %h actual %h",
                                 {$sampled(exp_len), 2'b01, 4'h0},
                                 $sampled({aw.len, aw.burst, aw.id})));

    a_ar_attr : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (ar.valid && arready) |-> ({ar.len, ar.burst, ar.id} == {exp_len, 2'b01, 4'h0})
    ) else report_fail($sformatf("Fail axi_ar_o len/burst/id expected %h actual %h",
                                 {$sampled(exp_len), 2'b01, 4'h0},
                                 $sampled({ar.len, ar.burst, ar.id})));

    // Watchdog
    initial
    begin
        repeat (200 * NUM_PKTS + 10) @(posedge clk_i);
        report_fail("Timeout: the packet sequence did not complete");
    end

    //------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------
    initial
    begin
        rst_i   = 1'b1;
        rx_q    = '0;
        gpio_in = 32'h5A3C_96E1;
        for (int a = 0; a < 256; a++)
            shadow[a] = '0;
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);

        run_echo(16'h0001, 4);
        run_echo(16'h0002, 0);
        run_write(CMD_WRITE_NP, 16'h0003, 32'h40, 6);
        run_read(16'h0004, 32'h40, 6);
        run_write(CMD_WRITE_NP, 16'h0005, 32'h100, 8);
        run_read(16'h0006, 32'h100, 8);

        // Sub-word writes to address 4k+2
        run_write(CMD_WRITE_NP, 16'h0007, 32'h88, 1);
        run_write(CMD_WRITE8, 16'h0008, 32'h8A, 1);
        run_read(16'h0009, 32'h88, 1);
        run_write(CMD_WRITE16, 16'h000A, 32'h8A, 1);
        run_read(16'h000B, 32'h88, 1);

        // GPIO write, pins follow one cycle after the data word
        push_exp({16'h0, 16'h000C});
        send_head(CMD_GPIO_WR, 1, 16'h000C, '0);
        send_word(32'hC0FF_EE42);
        exp_gpio = 32'hC0FF_EE42;
        rx_idle();
        wait_drained();
        push_exp(gpio_in);
        push_exp({16'h0, 16'h000D});
        send_head(CMD_GPIO_RD, 0, 16'h000D, '0);
        rx_idle();
        wait_drained();

        // Drain, then a normal echo
        send_head(CMD_DRAIN, 3, 16'h000E, '0);
        for (int i = 0; i < 3; i++)
            send_word(pattern_word(16'h000E, i));
        rx_idle();
        run_echo(16'h000F, 3);

        repeat (4) @(posedge clk_i);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* usb_bridge.f */
design/usb_bridge_pkg.sv
design/gpio_regs.sv
design/cmd_engine.sv
design/usb_bridge_top.sv
tb/axi_mem_model.sv
tb/usb_bridge_tb.sv
